// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= cpu_tb
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== flist.f ====
+incdir+sim
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_writeback.sv
logic/cpu_top.sv
sim/cpu_tb.sv

// ==== logic/cpu_pkg.sv ====
package cpu_pkg;

    localparam int word_width = 16;
    localparam int addr_width = 8;
    localparam int reg_index_width = 3;
    localparam int reg_count = 1 << reg_index_width;
    localparam int op_width = 5;

    // opcode map
    localparam logic [op_width-1:0] op_nop   = 5'b00000;
    localparam logic [op_width-1:0] op_halt  = 5'b00001;
    localparam logic [op_width-1:0] op_load  = 5'b00010;
    localparam logic [op_width-1:0] op_store = 5'b00011;
    localparam logic [op_width-1:0] op_sll   = 5'b00100;
    localparam logic [op_width-1:0] op_sla   = 5'b00101;
    localparam logic [op_width-1:0] op_srl   = 5'b00110;
    localparam logic [op_width-1:0] op_sra   = 5'b00111;
    localparam logic [op_width-1:0] op_add   = 5'b01000;
    localparam logic [op_width-1:0] op_addi  = 5'b01001;
    localparam logic [op_width-1:0] op_sub   = 5'b01010;
    localparam logic [op_width-1:0] op_subi  = 5'b01011;
    localparam logic [op_width-1:0] op_cmp   = 5'b01100;
    localparam logic [op_width-1:0] op_and   = 5'b01101;
    localparam logic [op_width-1:0] op_or    = 5'b01110;
    localparam logic [op_width-1:0] op_xor   = 5'b01111;
    localparam logic [op_width-1:0] op_ldih  = 5'b10000;
    localparam logic [op_width-1:0] op_jump  = 5'b11000;
    localparam logic [op_width-1:0] op_bz    = 5'b11010;
    localparam logic [op_width-1:0] op_bnz   = 5'b11011;
    localparam logic [op_width-1:0] op_bn    = 5'b11100;
    localparam logic [op_width-1:0] op_bnn   = 5'b11101;

    // run control
    localparam logic state_idle = 1'b0;
    localparam logic state_exec = 1'b1;

    // one instruction word, register or immediate layout
    typedef union packed {
        struct packed {
            logic [op_width-1:0]        opcode;
            logic [reg_index_width-1:0] r1;
            logic                       spare_a;
            logic [reg_index_width-1:0] r2;
            logic                       spare_b;
            logic [reg_index_width-1:0] r3;
        } reg_form;
        struct packed {
            logic [op_width-1:0]        opcode;
            logic [reg_index_width-1:0] r1;
            logic [3:0]                 val2;
            logic [3:0]                 val3;
        } imm_form;
    } instr_t;

    localparam instr_t nop_word = instr_t'({op_nop, {(word_width - op_width){1'b0}}});

endpackage

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic                           start,
    input  cpu_pkg::instr_t                instr,
    input  logic [cpu_pkg::word_width-1:0] d_datain,
    output logic [cpu_pkg::addr_width-1:0] pc,
    output logic [cpu_pkg::addr_width-1:0] d_addr,
    output logic                           d_we,
    output logic [cpu_pkg::word_width-1:0] d_dataout,
    output logic                           running
);

    import cpu_pkg::*;

    logic                       run;
    instr_t                     id_ir;
    instr_t                     ex_ir;
    instr_t                     mem_ir;
    logic [word_width-1:0]      reg_a;
    logic [word_width-1:0]      reg_b;
    logic [word_width-1:0]      reg_c;
    logic [word_width-1:0]      store_data;
    logic [word_width-1:0]      store_data_mem;
    logic                       zf;
    logic                       nf;
    logic                       branch_taken;
    logic [addr_width-1:0]      branch_target;
    logic                       halted;
    logic                       wb_we;
    logic [reg_index_width-1:0] wb_index;
    logic [word_width-1:0]      wb_data;

    assign running = run;

    fetch_stage fetch_i (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .start(start),
        .instr(instr),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .halted(halted),
        .run(run),
        .pc(pc),
        .id_ir(id_ir)
    );

    decode_stage decode_i (
        .clock(clock),
        .reset(reset),
        .run(run),
        .id_ir(id_ir),
        .wb_we(wb_we),
        .wb_index(wb_index),
        .wb_data(wb_data),
        .ex_ir(ex_ir),
        .reg_a(reg_a),
        .reg_b(reg_b),
        .store_data(store_data)
    );

    execute_stage execute_i (
        .clock(clock),
        .reset(reset),
        .run(run),
        .ex_ir(ex_ir),
        .reg_a(reg_a),
        .reg_b(reg_b),
        .store_data(store_data),
        .mem_ir(mem_ir),
        .reg_c(reg_c),
        .store_data_mem(store_data_mem),
        .zf(zf),
        .nf(nf)
    );

    memory_writeback memory_writeback_i (
        .clock(clock),
        .reset(reset),
        .run(run),
        .mem_ir(mem_ir),
        .reg_c(reg_c),
        .store_data_mem(store_data_mem),
        .zf(zf),
        .nf(nf),
        .d_datain(d_datain),
        .d_addr(d_addr),
        .d_we(d_we),
        .d_dataout(d_dataout),
        .branch_taken(branch_taken),
        .branch_target(branch_target),
        .wb_we(wb_we),
        .wb_index(wb_index),
        .wb_data(wb_data),
        .halted(halted)
    );

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                run,
    input  cpu_pkg::instr_t                     id_ir,
    input  logic                                wb_we,
    input  logic [cpu_pkg::reg_index_width-1:0] wb_index,
    input  logic [cpu_pkg::word_width-1:0]      wb_data,
    output cpu_pkg::instr_t                     ex_ir,
    output logic [cpu_pkg::word_width-1:0]      reg_a,
    output logic [cpu_pkg::word_width-1:0]      reg_b,
    output logic [cpu_pkg::word_width-1:0]      store_data
);

    import cpu_pkg::*;

    logic [word_width-1:0] regs [0:reg_count-1];
    logic [word_width-1:0] a_next;
    logic [word_width-1:0] b_next;
    logic [7:0]            imm8;
    logic [op_width-1:0]   id_op;

    assign id_op = id_ir.reg_form.opcode;
    assign imm8 = {id_ir.imm_form.val2, id_ir.imm_form.val3};

    // register file, written back from the last stage
    always_ff @(posedge clock)
    begin
        if (run && wb_we)
            regs[wb_index] <= wb_data;
    end

    always_comb
    begin
        case (id_op)
            op_jump:
                a_next = '0;
            op_ldih, op_addi, op_subi, op_bz, op_bnz, op_bn, op_bnn:
                a_next = regs[id_ir.imm_form.r1];
            default:
                a_next = regs[id_ir.reg_form.r2];
        endcase
    end

    always_comb
    begin
        case (id_op)
            op_add, op_sub, op_cmp, op_and, op_or, op_xor:
                b_next = regs[id_ir.reg_form.r3];
            op_load, op_store, op_sll, op_srl, op_sla, op_sra:
                b_next = {{(word_width - 4){1'b0}}, id_ir.imm_form.val3};
            op_addi, op_subi, op_jump, op_bz, op_bnz, op_bn, op_bnn:
                b_next = {{(word_width - 8){1'b0}}, imm8};
            // high byte load
            op_ldih:
                b_next = {imm8, {(word_width - 8){1'b0}}};
            default:
                b_next = '0;
        endcase
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
            ex_ir <= nop_word;
        else if (run)
            ex_ir <= id_ir;
    end

    always_ff @(posedge clock)
    begin
        if (run)
        begin
            reg_a <= a_next;
            reg_b <= b_next;
            if (id_op == op_store)
                store_data <= regs[id_ir.reg_form.r1];
        end
    end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           run,
    input  cpu_pkg::instr_t                ex_ir,
    input  logic [cpu_pkg::word_width-1:0] reg_a,
    input  logic [cpu_pkg::word_width-1:0] reg_b,
    input  logic [cpu_pkg::word_width-1:0] store_data,
    output cpu_pkg::instr_t                mem_ir,
    output logic [cpu_pkg::word_width-1:0] reg_c,
    output logic [cpu_pkg::word_width-1:0] store_data_mem,
    output logic                           zf,
    output logic                           nf
);

    import cpu_pkg::*;

    logic [op_width-1:0]   ex_op;
    logic [word_width-1:0] alu_out;
    logic                  set_flags;

    assign ex_op = ex_ir.reg_form.opcode;

    always_comb
    begin
        case (ex_op)
            op_and:
                alu_out = reg_a & reg_b;
            op_or:
                alu_out = reg_a | reg_b;
            op_xor:
                alu_out = reg_a ^ reg_b;
            // arithmetic left is the same as logical left
            op_sll, op_sla:
                alu_out = reg_a << reg_b[3:0];
            op_srl:
                alu_out = reg_a >> reg_b[3:0];
            op_sra:
                alu_out = $signed(reg_a) >>> reg_b[3:0];
            op_sub, op_subi, op_cmp:
                alu_out = reg_a - reg_b;
            // also address and branch target arithmetic
            default:
                alu_out = reg_a + reg_b;
        endcase
    end

    always_comb
    begin
        case (ex_op)
            op_add, op_addi, op_sub, op_subi, op_cmp, op_and, op_or, op_xor,
            op_sll, op_srl, op_sla, op_sra, op_ldih:
                set_flags = 1'b1;
            default:
                set_flags = 1'b0;
        endcase
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            mem_ir <= nop_word;
            zf <= 1'b0;
            nf <= 1'b0;
        end
        else if (run)
        begin
            mem_ir <= ex_ir;
            if (set_flags)
            begin
                zf <= (alu_out == '0);
                nf <= alu_out[word_width-1];
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (run)
        begin
            reg_c <= alu_out;
            if (ex_op == op_store)
                store_data_mem <= store_data;
        end
    end

    // branch conditions must not shift under a stalled pipeline
    flags_frozen_check: assert property (@(posedge clock) disable iff (reset)
        !run |=> ($stable(zf) && $stable(nf)));

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic                           start,
    input  cpu_pkg::instr_t                instr,
    input  logic                           branch_taken,
    input  logic [cpu_pkg::addr_width-1:0] branch_target,
    input  logic                           halted,
    output logic                           run,
    output logic [cpu_pkg::addr_width-1:0] pc,
    output cpu_pkg::instr_t                id_ir
);

    import cpu_pkg::*;

    logic state;
    logic next_state;

    always_comb
    begin
        next_state = state;
        case (state)
            state_idle:
                if (enable && start)
                    next_state = state_exec;
            state_exec:
                if (!enable || halted)
                    next_state = state_idle;
            default:
                next_state = state_idle;
        endcase
    end

    assign run = (state == state_exec);

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            state <= state_idle;
            pc <= '0;
            id_ir <= nop_word;
        end
        else
        begin
            state <= next_state;
            if (run)
            begin
                id_ir <= instr;
                // branch resolves in memory stage, three slots already fetched
                if (branch_taken)
                    pc <= branch_target;
                else
                    pc <= pc + 1'b1;
            end
        end
    end

    // pc holds across a frozen pipeline
    pc_frozen_check: assert property (@(posedge clock) disable iff (reset)
        !run |=> $stable(pc));

endmodule

// ==== logic/memory_writeback.sv ====
`timescale 1ns/1ps

module memory_writeback (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                run,
    input  cpu_pkg::instr_t                     mem_ir,
    input  logic [cpu_pkg::word_width-1:0]      reg_c,
    input  logic [cpu_pkg::word_width-1:0]      store_data_mem,
    input  logic                                zf,
    input  logic                                nf,
    input  logic [cpu_pkg::word_width-1:0]      d_datain,
    output logic [cpu_pkg::addr_width-1:0]      d_addr,
    output logic                                d_we,
    output logic [cpu_pkg::word_width-1:0]      d_dataout,
    output logic                                branch_taken,
    output logic [cpu_pkg::addr_width-1:0]      branch_target,
    output logic                                wb_we,
    output logic [cpu_pkg::reg_index_width-1:0] wb_index,
    output logic [cpu_pkg::word_width-1:0]      wb_data,
    output logic                                halted
);

    import cpu_pkg::*;

    instr_t              wb_ir;
    logic [op_width-1:0] mem_op;
    logic [op_width-1:0] wb_op;
    logic                writes_reg;

    assign mem_op = mem_ir.reg_form.opcode;
    assign wb_op = wb_ir.reg_form.opcode;

    always_comb
    begin
        case (mem_op)
            op_jump:
                branch_taken = 1'b1;
            op_bz:
                branch_taken = zf;
            op_bnz:
                branch_taken = !zf;
            op_bn:
                branch_taken = nf;
            op_bnn:
                branch_taken = !nf;
            default:
                branch_taken = 1'b0;
        endcase
    end

    assign branch_target = reg_c[addr_width-1:0];
    assign d_addr = reg_c[addr_width-1:0];
    assign d_we = run && (mem_op == op_store);
    assign d_dataout = store_data_mem;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
            wb_ir <= nop_word;
        else if (run)
            wb_ir <= mem_ir;
    end

    always_ff @(posedge clock)
    begin
        if (run)
            wb_data <= (mem_op == op_load) ? d_datain : reg_c;
    end

    // cmp only sets flags
    always_comb
    begin
        case (wb_op)
            op_load, op_ldih, op_add, op_addi, op_sub, op_subi, op_and, op_or,
            op_xor, op_sll, op_srl, op_sla, op_sra:
                writes_reg = 1'b1;
            default:
                writes_reg = 1'b0;
        endcase
    end

    assign wb_we = run && writes_reg;
    assign wb_index = wb_ir.reg_form.r1;
    assign halted = (wb_op == op_halt);

    no_store_on_branch_check: assert property (@(posedge clock) disable iff (reset)
        !(d_we && branch_taken));

endmodule

// ==== sim/cpu_programs.svh ====
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

// per test the name, its slice of prog_q and the cycle where enable drops (0 for none)
// per expected store the test index, the address and a value or preload source
string                 test_name[$];
int                    prog_first[$];
int                    prog_count[$];
int                    pause_at[$];
logic [word_width-1:0] prog_q[$];
int                    exp_test[$];
logic [addr_width-1:0] exp_addr[$];
logic [word_width-1:0] exp_data[$];
int                    exp_src[$];

function automatic logic [word_width-1:0] enc_rr(logic [op_width-1:0] op, int d, int a, int b);
    return {op, d[2:0], 1'b0, a[2:0], 1'b0, b[2:0]};
endfunction

function automatic logic [word_width-1:0] enc_ri(logic [op_width-1:0] op, int d, logic [7:0] imm);
    return {op, d[2:0], imm};
endfunction

// loads, stores and shifts take base or source in r2 and a 4-bit value in val3
function automatic logic [word_width-1:0] enc_rm(logic [op_width-1:0] op, int d, int a,
                                                 logic [3:0] v);
    return {op, d[2:0], 1'b0, a[2:0], v};
endfunction

task automatic begin_test(string name, int pause);
    test_name.push_back(name);
    prog_first.push_back(prog_q.size());
    prog_count.push_back(0);
    pause_at.push_back(pause);
endtask

task automatic emit(logic [word_width-1:0] w);
    prog_q.push_back(w);
    prog_count[prog_count.size() - 1]++;
endtask

// three nops keep the next reader clear of the write
task automatic emit_spaced(logic [word_width-1:0] w);
    emit(w);
    repeat (3) emit(nop_word);
endtask

task automatic clear_regs();
    for (int r = 0; r < reg_count; r++)
        emit_spaced(enc_rr(op_sub, r, r, r));
endtask

task automatic end_program();
    emit(enc_rr(op_halt, 0, 0, 0));
    repeat (3) emit(nop_word);
endtask

task automatic expect_store(int a, logic [word_width-1:0] v);
    exp_test.push_back(test_name.size() - 1);
    exp_addr.push_back(a[addr_width-1:0]);
    exp_data.push_back(v);
    exp_src.push_back(-1);
endtask

task automatic expect_copy(int a, int src);
    exp_test.push_back(test_name.size() - 1);
    exp_addr.push_back(a[addr_width-1:0]);
    exp_data.push_back('0);
    exp_src.push_back(src);
endtask

// flag op and branch with three slot stores, then a not-taken marker and a jump past the target
task automatic branch_block(logic [op_width-1:0] op, int ca, int cb, int base_reg,
                            int base_addr, bit taken);
    int t0;
    emit(enc_rr(op_cmp, 0, ca, cb));
    t0 = prog_count[prog_count.size() - 1];
    emit(enc_ri(op, 0, 8'(t0 + 9)));
    for (int k = 0; k < 3; k++)
        emit(enc_rm(op_store, 5, base_reg, 4'(k)));
    emit(enc_rm(op_store, 6, base_reg, 4'd3));
    emit(enc_ri(op_jump, 0, 8'(t0 + 10)));
    repeat (3) emit(nop_word);
    emit(enc_rm(op_store, 7, base_reg, 4'd4));
    for (int k = 0; k < 3; k++)
        expect_store(base_addr + k, 16'h0011);
    if (taken)
    begin
        expect_copy(base_addr + 3, base_addr + 3);
        expect_store(base_addr + 4, 16'h0033);
    end
    else
    begin
        expect_store(base_addr + 3, 16'h0022);
        expect_copy(base_addr + 4, base_addr + 4);
    end
endtask

task automatic build_tests();
    begin_test("alu", 0);
    clear_regs();
    emit_spaced(enc_ri(op_ldih, 1, 8'h12));
    emit_spaced(enc_ri(op_addi, 1, 8'h34));
    emit_spaced(enc_ri(op_ldih, 2, 8'hf0));
    emit_spaced(enc_ri(op_addi, 2, 8'h0f));
    emit_spaced(enc_rr(op_add, 3, 1, 2));
    emit_spaced(enc_rr(op_sub, 4, 1, 2));
    emit_spaced(enc_rr(op_and, 5, 1, 2));
    emit_spaced(enc_rr(op_or, 6, 1, 2));
    emit_spaced(enc_rr(op_xor, 7, 1, 2));
    for (int r = 3; r < 8; r++)
        emit(enc_rm(op_store, r, 0, 4'(r - 2)));
    emit_spaced(enc_ri(op_subi, 1, 8'h34));
    emit(enc_rm(op_store, 1, 0, 4'd6));
    end_program();
    expect_store(1, 16'h0243);
    expect_store(2, 16'h2225);
    expect_store(3, 16'h1004);
    expect_store(4, 16'hf23f);
    expect_store(5, 16'he23b);
    expect_store(6, 16'h1200);

    begin_test("shift_cmp", 0);
    clear_regs();
    emit_spaced(enc_ri(op_ldih, 1, 8'h80));
    emit_spaced(enc_ri(op_addi, 1, 8'h01));
    emit_spaced(enc_ri(op_addi, 6, 8'h55));
    emit_spaced(enc_rm(op_sll, 2, 1, 4'd4));
    emit_spaced(enc_rm(op_srl, 3, 1, 4'd15));
    emit_spaced(enc_rm(op_sra, 4, 1, 4'd3));
    emit_spaced(enc_rm(op_sla, 5, 1, 4'd1));
    emit_spaced(enc_rr(op_cmp, 6, 1, 1));
    for (int r = 2; r < 7; r++)
        emit(enc_rm(op_store, r, 0, 4'(r + 8)));
    end_program();
    expect_store(10, 16'h0010);
    expect_store(11, 16'h0001);
    expect_store(12, 16'hf000);
    expect_store(13, 16'h0002);
    expect_store(14, 16'h0055);

    begin_test("load_store", 0);
    clear_regs();
    emit_spaced(enc_ri(op_addi, 2, 8'h40));
    emit(enc_rm(op_load, 1, 2, 4'd3));
    emit_spaced(enc_rm(op_load, 3, 2, 4'd9));
    emit(enc_rm(op_store, 1, 0, 4'd2));
    emit(enc_rm(op_store, 3, 0, 4'd7));
    end_program();
    expect_copy(2, 8'h43);
    expect_copy(7, 8'h49);

    begin_test("branches", 0);
    clear_regs();
    emit_spaced(enc_ri(op_addi, 5, 8'h11));
    emit_spaced(enc_ri(op_addi, 6, 8'h22));
    emit_spaced(enc_ri(op_addi, 7, 8'h33));
    for (int r = 1; r < 5; r++)
        emit_spaced(enc_ri(op_addi, r, 8'(8'h10 + 16 * r)));
    branch_block(op_bz, 0, 0, 1, 8'h20, 1'b1);
    branch_block(op_bnz, 0, 0, 2, 8'h30, 1'b0);
    branch_block(op_bn, 0, 5, 3, 8'h40, 1'b1);
    branch_block(op_bnn, 0, 5, 4, 8'h50, 1'b0);
    end_program();

    begin_test("run_control", 40);
    clear_regs();
    emit_spaced(enc_ri(op_addi, 1, 8'h77));
    for (int k = 1; k < 9; k++)
    begin
        emit(enc_rm(op_store, 1, 0, 4'(k)));
        expect_store(k, 16'h0077);
    end
    end_program();
endtask

`endif

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    import cpu_pkg::*;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  enable;
    logic                  start;
    instr_t                instr;
    logic [word_width-1:0] d_datain;
    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] d_addr;
    logic                  d_we;
    logic [word_width-1:0] d_dataout;
    logic                  running;

    logic [word_width-1:0] rom [0:255];
    logic [word_width-1:0] dmem [0:255];
    logic [word_width-1:0] preload [0:255];
    logic [31:0]           lfsr_state = 32'd32;
    int                    errors = 0;
    int                    store_count = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;

    `include "cpu_programs.svh"

    cpu_top dut_i (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .start(start),
        .instr(instr),
        .d_datain(d_datain),
        .pc(pc),
        .d_addr(d_addr),
        .d_we(d_we),
        .d_dataout(d_dataout),
        .running(running)
    );

    always #10 clock = ~clock;

    // instruction rom and data memory answer in the same cycle
    assign instr = rom[pc];
    assign d_datain = dmem[d_addr];

    always @(posedge clock)
    begin
        if (d_we)
        begin
            dmem[d_addr] <= d_dataout;
            store_count++;
        end
    end

    always @(posedge clock)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
        begin
            $display("timeout after %0d cycles, the core never went idle", cycle_count);
            errors++;
            $display("errors: %0d", errors);
            $display("Something failed");
            $finish;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [word_width-1:0] w);
        w = '0;
        for (int i = 0; i < word_width; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[word_width-2:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(string name, logic [word_width-1:0] expected,
                              logic [word_width-1:0] actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_addr(string name, logic [addr_width-1:0] expected,
                              logic [addr_width-1:0] actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected)
        begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic pulse_start();
        @(posedge clock);
        enable <= 1'b1;
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic run_test(int t);
        int                    cycles;
        bit                    seen_run;
        logic [addr_width-1:0] pc_hold;
        int                    count_hold;
        logic [word_width-1:0] expected;
        @(posedge clock);
        reset <= 1'b1;
        enable <= 1'b0;
        start <= 1'b0;
        for (int a = 0; a < 256; a++)
        begin
            rom[a] = nop_word;
            random_word(preload[a]);
            dmem[a] = preload[a];
        end
        for (int i = 0; i < prog_count[t]; i++)
            rom[i] = prog_q[prog_first[t] + i];
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_bit({test_name[t], " running after reset"}, 1'b0, running);
        check_bit({test_name[t], " d_we after reset"}, 1'b0, d_we);
        check_addr({test_name[t], " pc after reset"}, '0, pc);
        pulse_start();
        cycles = 0;
        seen_run = 0;
        while (!seen_run || running)
        begin
            @(negedge clock);
            cycles++;
            if (running)
                seen_run = 1;
            if (cycles == pause_at[t])
            begin
                @(posedge clock);
                enable <= 1'b0;
                repeat (2) @(negedge clock);
                pc_hold = pc;
                count_hold = store_count;
                repeat (3) @(negedge clock);
                check_bit({test_name[t], " running while paused"}, 1'b0, running);
                check_addr({test_name[t], " pc while paused"}, pc_hold, pc);
                check_word({test_name[t], " stores while paused"}, 16'(count_hold),
                           16'(store_count));
                pulse_start();
                // running is settled again by the falling edge
                @(negedge clock);
            end
        end
        for (int e = 0; e < exp_test.size(); e++)
        begin
            if (exp_test[e] == t)
            begin
                expected = (exp_src[e] < 0) ? exp_data[e] : preload[exp_src[e]];
                check_word($sformatf("%s store at %h", test_name[t], exp_addr[e]),
                           expected, dmem[exp_addr[e]]);
            end
        end
    endtask

    initial
    begin
        reset = 1'b1;
        enable = 1'b0;
        start = 1'b0;
        for (int a = 0; a < 256; a++)
        begin
            rom[a] = nop_word;
            dmem[a] = 16'(a);
        end
        build_tests();
        cycle_limit = 2 * prog_q.size() + 50 * test_name.size();
        for (int t = 0; t < test_name.size(); t++)
            run_test(t);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
